//--- verilog/pack_defines.svh
// frame format and credit sizes for the frame packer, included by the package and the RTL
`ifndef PACK_DEFINES_SVH
`define PACK_DEFINES_SVH

// ------------------------------------------------------------
// frame layout
// ------------------------------------------------------------

// first header byte
`define PACK_SYNC_BYTE 8'hA5

// sync, sequence, opcode, length
`define PACK_HEAD_BYTES 4

// bitmap bytes per frame, also the bitmap buffer depth
`define PACK_BM_BYTES 16

// extension word bytes, sent msb first
`define PACK_EXP_BYTES 16

`define PACK_FRAME_BYTES 36

// ------------------------------------------------------------
// sink credits
// ------------------------------------------------------------

// sink buffer depth in bytes
`define PACK_CREDIT_MAX 64

// counter holds 0..64
`define PACK_CREDIT_W 7

`endif

//--- verilog/pack_pkg.sv
// shared opcode and state enums plus the packed request, stream and host write structs
`default_nettype none

`include "pack_defines.svh"

package pack_pkg;

	// ------------------------------------------------------------
	// enums
	// ------------------------------------------------------------

	// sent unchanged as header byte 2
	typedef enum logic [7:0] {
		OP_DATA = 8'h01,
		OP_CTRL = 8'h02,
		OP_MGMT = 8'h03
	} pack_op_e;

	typedef enum logic [1:0] {
		IDLE      = 2'h0,
		HEAD      = 2'h1,
		TAIL      = 2'h2,
		WAIT_DONE = 2'h3
	} ctrl_state_e;

	// tail stage sequence
	typedef enum logic [2:0] {
		S_IDLE = 3'h0,
		S_PREP = 3'h1,
		S_RBMF = 3'h2,
		S_RDBM = 3'h3,
		S_RBML = 3'h4,
		S_RDEP = 3'h6,
		S_DONE = 3'h7
	} tail_state_e;

	// ------------------------------------------------------------
	// structs
	// ------------------------------------------------------------

	// one frame request from the requester
	typedef struct packed {
		pack_op_e                         op;
		logic [`PACK_EXP_BYTES*8-1:0] exp_data;
	} frame_req_t;

	// output stream item
	typedef struct packed {
		logic [7:0] data;
		logic       sof;
		logic       eof;
	} pack_byte_t;

	// host write into the bitmap buffer
	typedef struct packed {
		logic [3:0] addr;
		logic [7:0] data;
	} bm_wr_t;

endpackage

`default_nettype wire

//--- verilog/bm_ram.sv
// bitmap buffer, written by the host and read out in address order by the tail stage
`default_nettype none

`include "pack_defines.svh"

module bm_ram (
	input  wire                  clk_sys,
	input  wire                  rst_n,
	input  wire                  bm_wr_en,
	input  wire pack_pkg::bm_wr_t bm_wr,
	input  wire                  bm_req,
	output logic [7:0]           bm_q
);

	// 16 x 8 storage
	logic [7:0] mem [0:`PACK_BM_BYTES-1];

	// read address, one step per request
	logic [3:0] rd_ptr;

	// ------------------------------------------------------------
	// host write port
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys) begin
		if (bm_wr_en) begin
			mem[bm_wr.addr] <= bm_wr.data;
		end
	end

	// ------------------------------------------------------------
	// read port
	// ------------------------------------------------------------

	// wraps back to 0 after 16 reads, so every frame starts at address 0
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= 4'h0;
		end else if (bm_req) begin
			rd_ptr <= rd_ptr + 4'h1;
		end
	end

	// data shows up the cycle after the request
	always_ff @(posedge clk_sys) begin
		if (bm_req) begin
			bm_q <= mem[rd_ptr];
		end
	end

endmodule

`default_nettype wire

//--- verilog/pack_head.sv
// header byte generator, emits sync, sequence number, opcode and payload length after fire_head
`default_nettype none

`include "pack_defines.svh"

module pack_head (
	input  wire                    clk_sys,
	input  wire                    rst_n,
	input  wire                    fire_head,
	input  wire pack_pkg::pack_op_e op,
	output logic                   head_vld,
	output logic [7:0]             head_data,
	output logic                   head_last
);

	localparam logic [1:0] LAST_IDX = 2'(`PACK_HEAD_BYTES - 1);
	localparam logic [7:0] PAY_LEN = 8'(`PACK_BM_BYTES + `PACK_EXP_BYTES);

	logic       active;
	logic [1:0] idx;

	// frame sequence number
	logic [7:0] seq;

	// ------------------------------------------------------------
	// byte counter
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			idx    <= 2'h0;
			seq    <= 8'h0;
		end else if (fire_head) begin
			active <= 1'b1;
			idx    <= 2'h0;
		end else if (active) begin
			idx <= idx + 2'h1;
			// next number only once this header is out
			if (idx == LAST_IDX) begin
				active <= 1'b0;
				seq    <= seq + 8'h1;
			end
		end
	end

	// ------------------------------------------------------------
	// byte select
	// ------------------------------------------------------------

	always_comb begin
		case (idx)
			2'h0:    head_data = `PACK_SYNC_BYTE;
			2'h1:    head_data = seq;
			2'h2:    head_data = op;
			default: head_data = PAY_LEN;
		endcase
	end

	assign head_vld  = active;
	assign head_last = active && (idx == LAST_IDX);

endmodule

`default_nettype wire

//--- verilog/pack_tail.sv
// tail stage, streams the 16 bitmap bytes and then the extension word msb first, then pulses done
`default_nettype none

`include "pack_defines.svh"

module pack_tail (
	input  wire                           clk_sys,
	input  wire                           rst_n,
	input  wire                           fire_tail,
	input  wire [`PACK_EXP_BYTES*8-1:0] exp_data,
	input  wire [7:0]                     bm_q,
	output logic                          bm_req,
	output logic                          tail_vld,
	output logic [7:0]                    tail_data,
	output logic                          tail_last,
	output logic                          done_tail
);

	localparam int EXP_W = `PACK_EXP_BYTES * 8;

	// RDBM covers bitmap bytes 0 to 14, RBML the last one
	localparam logic [3:0] BM_END = 4'(`PACK_BM_BYTES - 2);
	localparam logic [3:0] EP_END = 4'(`PACK_EXP_BYTES - 1);

	pack_pkg::tail_state_e state;

	logic [3:0] cnt_bm;
	logic [3:0] cnt_ep;
	logic       finish_bm;
	logic       finish_ep;

	// extension word shift register
	logic [EXP_W-1:0] lock_ep;

	// ------------------------------------------------------------
	// main FSM
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= pack_pkg::S_IDLE;
		end else begin
			case (state)
				pack_pkg::S_IDLE: begin
					if (fire_tail) begin
						state <= pack_pkg::S_PREP;
					end
				end
				pack_pkg::S_PREP: state <= pack_pkg::S_RBMF;
				pack_pkg::S_RBMF: state <= pack_pkg::S_RDBM;
				pack_pkg::S_RDBM: begin
					if (finish_bm) begin
						state <= pack_pkg::S_RBML;
					end
				end
				pack_pkg::S_RBML: state <= pack_pkg::S_RDEP;
				pack_pkg::S_RDEP: begin
					if (finish_ep) begin
						state <= pack_pkg::S_DONE;
					end
				end
				default: state <= pack_pkg::S_IDLE;
			endcase
		end
	end

	// ------------------------------------------------------------
	// phase counters
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			cnt_bm <= 4'h0;
			cnt_ep <= 4'h0;
		end else begin
			cnt_bm <= (state == pack_pkg::S_RDBM) ? cnt_bm + 4'h1 : 4'h0;
			cnt_ep <= (state == pack_pkg::S_RDEP) ? cnt_ep + 4'h1 : 4'h0;
		end
	end

	assign finish_bm = (cnt_bm == BM_END);
	assign finish_ep = (cnt_ep == EP_END);

	// load in PREP, then one byte left per RDEP cycle
	always_ff @(posedge clk_sys) begin
		if (state == pack_pkg::S_PREP) begin
			lock_ep <= exp_data;
		end else if (state == pack_pkg::S_RDEP) begin
			lock_ep <= {lock_ep[EXP_W-9:0], 8'h0};
		end
	end

	// ------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------

	assign bm_req = (state == pack_pkg::S_RBMF) || (state == pack_pkg::S_RDBM);

	assign tail_vld = (state == pack_pkg::S_RDBM) || (state == pack_pkg::S_RBML) ||
		(state == pack_pkg::S_RDEP);

	// RBML forwards the last bitmap byte too
	always_comb begin
		case (state)
			pack_pkg::S_RDBM, pack_pkg::S_RBML: tail_data = bm_q;
			pack_pkg::S_RDEP:                   tail_data = lock_ep[EXP_W-1 -: 8];
			default:                            tail_data = 8'h0;
		endcase
	end

	assign tail_last = (state == pack_pkg::S_RDEP) && finish_ep;
	assign done_tail = (state == pack_pkg::S_DONE);

endmodule

`default_nettype wire

//--- verilog/pack_ctrl.sv
// admits frame requests against sink credits and drives head, tail and the output stream in the packer top level
`default_nettype none

`include "pack_defines.svh"

module pack_ctrl (
	input  wire                           clk_sys,
	input  wire                           rst_n,
	input  wire                           frame_req,
	input  wire pack_pkg::frame_req_t     frame_in,
	input  wire                           credit_rtn,
	input  wire                           head_vld,
	input  wire [7:0]                     head_data,
	input  wire                           head_last,
	input  wire                           tail_vld,
	input  wire [7:0]                     tail_data,
	input  wire                           tail_last,
	input  wire                           done_tail,
	output logic                          frame_ack,
	output logic                          fire_head,
	output pack_pkg::pack_op_e            op,
	output logic                          fire_tail,
	output logic [`PACK_EXP_BYTES*8-1:0] exp_data,
	output logic                          tx_vld,
	output pack_pkg::pack_byte_t          tx_byte
);

	localparam logic [`PACK_CREDIT_W-1:0] CREDIT_INIT = `PACK_CREDIT_MAX;
	localparam logic [`PACK_CREDIT_W-1:0] FRAME_NEED = `PACK_FRAME_BYTES;
	localparam logic [`PACK_CREDIT_W-1:0] CREDIT_STEP = 1;

	pack_pkg::ctrl_state_e state;
	pack_pkg::frame_req_t  frame_q;

	logic [`PACK_CREDIT_W-1:0] credit;
	logic                      credit_ok;

	// next head byte is the first of the frame
	logic                      sof_pend;

	// ------------------------------------------------------------
	// admission and sequencing
	// ------------------------------------------------------------

	// whole frame must fit in the sink before we start
	assign credit_ok = (credit >= FRAME_NEED);
	assign frame_ack = (state == pack_pkg::IDLE) && frame_req && credit_ok;
	assign fire_head = frame_ack;
	assign fire_tail = (state == pack_pkg::HEAD) && head_last;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state <= pack_pkg::IDLE;
		end else begin
			case (state)
				pack_pkg::IDLE: begin
					if (frame_ack) begin
						state <= pack_pkg::HEAD;
					end
				end
				pack_pkg::HEAD: begin
					if (head_last) begin
						state <= pack_pkg::TAIL;
					end
				end
				pack_pkg::TAIL: begin
					if (tail_last) begin
						state <= pack_pkg::WAIT_DONE;
					end
				end
				default: begin
					if (done_tail) begin
						state <= pack_pkg::IDLE;
					end
				end
			endcase
		end
	end

	// request held for the whole frame
	always_ff @(posedge clk_sys) begin
		if (frame_ack) begin
			frame_q <= frame_in;
		end
	end

	assign op       = frame_q.op;
	assign exp_data = frame_q.exp_data;

	// ------------------------------------------------------------
	// credits
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			credit <= CREDIT_INIT;
		end else begin
			case ({tx_vld, credit_rtn})
				2'b10:   credit <= credit - CREDIT_STEP;
				2'b01:   credit <= credit + CREDIT_STEP;
				default: credit <= credit;
			endcase
		end
	end

	// ------------------------------------------------------------
	// output stream
	// ------------------------------------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sof_pend <= 1'b0;
		end else if (frame_ack) begin
			sof_pend <= 1'b1;
		end else if (head_vld) begin
			sof_pend <= 1'b0;
		end
	end

	// head and tail never overlap
	always_comb begin
		tx_vld       = head_vld | tail_vld;
		tx_byte.data = head_vld ? head_data : tail_data;
		tx_byte.sof  = head_vld & sof_pend;
		tx_byte.eof  = tail_vld & tail_last;
	end

endmodule

`default_nettype wire

//--- verilog/pack_top.sv
// frame packer top level, wires control, header generator, tail stage and bitmap buffer
`default_nettype none

`include "pack_defines.svh"

module pack_top (
	input  wire                       clk_sys,
	input  wire                       rst_n,
	input  wire                       frame_req,
	input  wire pack_pkg::frame_req_t frame_in,
	input  wire                       credit_rtn,
	input  wire                       bm_wr_en,
	input  wire pack_pkg::bm_wr_t     bm_wr,
	output logic                      frame_ack,
	output logic                      tx_vld,
	output pack_pkg::pack_byte_t      tx_byte
);

	// ctrl to head
	logic                          fire_head;
	pack_pkg::pack_op_e            op;
	logic                          head_vld;
	logic [7:0]                    head_data;
	logic                          head_last;

	// ctrl to tail
	logic                          fire_tail;
	logic [`PACK_EXP_BYTES*8-1:0] exp_data;
	logic                          tail_vld;
	logic [7:0]                    tail_data;
	logic                          tail_last;
	logic                          done_tail;

	// tail to bitmap buffer
	logic                          bm_req;
	logic [7:0]                    bm_q;

	pack_ctrl i_ctrl (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.frame_req  (frame_req),
		.frame_in   (frame_in),
		.credit_rtn (credit_rtn),
		.head_vld   (head_vld),
		.head_data  (head_data),
		.head_last  (head_last),
		.tail_vld   (tail_vld),
		.tail_data  (tail_data),
		.tail_last  (tail_last),
		.done_tail  (done_tail),
		.frame_ack  (frame_ack),
		.fire_head  (fire_head),
		.op         (op),
		.fire_tail  (fire_tail),
		.exp_data   (exp_data),
		.tx_vld     (tx_vld),
		.tx_byte    (tx_byte)
	);

	pack_head i_head (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.fire_head (fire_head),
		.op        (op),
		.head_vld  (head_vld),
		.head_data (head_data),
		.head_last (head_last)
	);

	pack_tail i_tail (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.fire_tail (fire_tail),
		.exp_data  (exp_data),
		.bm_q      (bm_q),
		.bm_req    (bm_req),
		.tail_vld  (tail_vld),
		.tail_data (tail_data),
		.tail_last (tail_last),
		.done_tail (done_tail)
	);

	bm_ram i_bm_ram (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.bm_wr_en (bm_wr_en),
		.bm_wr    (bm_wr),
		.bm_req   (bm_req),
		.bm_q     (bm_q)
	);

endmodule

`default_nettype wire

//--- tb/tb_pack.sv
// table-driven testbench that runs as the top module and drives the frame packer top level as DUT
`default_nettype none

`include "pack_defines.svh"

module tb_pack;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_ROWS      = 6;
	localparam int BM_W        = `PACK_BM_BYTES * 8;
	localparam int EXP_W       = `PACK_EXP_BYTES * 8;
	localparam int FRAME_BYTES = `PACK_FRAME_BYTES;
	localparam int CREDIT_MAX  = `PACK_CREDIT_MAX;

	// one stimulus row with bitmap address 0 in the top byte
	typedef struct packed {
		pack_pkg::pack_op_e op;
		logic [EXP_W-1:0]   exp_word;
		logic [BM_W-1:0]    bitmap;
		logic               hold;
	} stim_row_t;

	localparam stim_row_t ROWS [N_ROWS] = '{
		'{pack_pkg::OP_DATA, 128'h00112233_44556677_8899AABB_CCDDEEFF,
			128'h01020304_05060708_090A0B0C_0D0E0F10, 1'b0},
		'{pack_pkg::OP_CTRL, 128'hF0E1D2C3_B4A59687_78695A4B_3C2D1E0F,
			128'hFFEEDDCC_BBAA9988_77665544_33221100, 1'b0},
		'{pack_pkg::OP_MGMT, 128'h80000000_00000000_00000000_00000001,
			128'h55AA55AA_A55A5AA5_0FF0F00F_C33C3CC3, 1'b1},
		'{pack_pkg::OP_DATA, 128'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF,
			128'h00000000_00000000_00000000_00000000, 1'b1},
		'{pack_pkg::OP_CTRL, 128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210,
			128'h3C3D3E3F_40414243_44454647_48494A4B, 1'b0},
		'{pack_pkg::OP_MGMT, 128'h13579BDF_2468ACE0_0ECA8642_FDB97531,
			128'h80402010_08040201_01020408_10204080, 1'b1}
	};

	logic                 clk_sys;
	logic                 rst_n;
	logic                 frame_req;
	pack_pkg::frame_req_t frame_in;
	logic                 credit_rtn;
	logic                 bm_wr_en;
	pack_pkg::bm_wr_t     bm_wr;
	logic                 frame_ack;
	logic                 tx_vld;
	pack_pkg::pack_byte_t tx_byte;

	// expected stream of the frame in flight
	pack_pkg::pack_byte_t exp_q [$];
	pack_pkg::pack_op_e   exp_op;
	int                   rx_idx;
	logic [7:0]           frame_seq;

	// sink side view of the DUT credit count
	int   credit_model = CREDIT_MAX;
	logic hold;

	int err_byte;
	int err_op;
	int err_proto;

	pack_top i_dut (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.frame_req  (frame_req),
		.frame_in   (frame_in),
		.credit_rtn (credit_rtn),
		.bm_wr_en   (bm_wr_en),
		.bm_wr      (bm_wr),
		.frame_ack  (frame_ack),
		.tx_vld     (tx_vld),
		.tx_byte    (tx_byte)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------

	// galois lfsr for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic check_byte(input pack_pkg::pack_byte_t got, input pack_pkg::pack_byte_t exp);
		if (got !== exp) begin
			err_byte++;
			$display("Error at %0t ns: frame %0d byte %0d got %h sof %b eof %b exp %h %b %b",
				$time, frame_seq, rx_idx, got.data, got.sof, got.eof, exp.data, exp.sof, exp.eof);
		end
	endtask

	task automatic check_op(input pack_pkg::pack_op_e got, input pack_pkg::pack_op_e exp);
		if (got !== exp) begin
			err_op++;
			$display("Error at %0t ns: frame %0d opcode got %h, expected %h",
				$time, frame_seq, got, exp);
		end
	endtask

	task automatic write_bitmap(input logic [BM_W-1:0] bits);
		int i;
		for (i = 0; i < `PACK_BM_BYTES; i++) begin
			@(posedge clk_sys);
			#1;
			bm_wr_en   = 1'b1;
			bm_wr.addr = 4'(i);
			bm_wr.data = bits[BM_W-1-8*i -: 8];
		end
		@(posedge clk_sys);
		#1;
		bm_wr_en = 1'b0;
	endtask

	// frame image built from the format as header then bitmap then extension msb first
	task automatic load_expected(input stim_row_t row, input logic [7:0] seq);
		pack_pkg::pack_byte_t b;
		int i;
		b      = '0;
		b.data = 8'hA5;
		b.sof  = 1'b1;
		exp_q.push_back(b);
		b      = '0;
		b.data = seq;
		exp_q.push_back(b);
		b.data = row.op;
		exp_q.push_back(b);
		// payload length is fixed at 32
		b.data = 8'd32;
		exp_q.push_back(b);
		for (i = 0; i < `PACK_BM_BYTES; i++) begin
			b.data = row.bitmap[BM_W-1-8*i -: 8];
			exp_q.push_back(b);
		end
		for (i = 0; i < `PACK_EXP_BYTES; i++) begin
			b.data = row.exp_word[EXP_W-1-8*i -: 8];
			b.eof  = (i == `PACK_EXP_BYTES - 1);
			exp_q.push_back(b);
		end
		exp_op = row.op;
		rx_idx = 0;
	endtask

	// ------------------------------------------------------------
	// sink returning credits at a random rate
	// ------------------------------------------------------------

	initial begin
		logic [15:0] lfsr;
		logic        take;
		lfsr       = 16'd6442;
		credit_rtn = 1'b0;
		forever begin
			@(posedge clk_sys);
			#1;
			take = lfsr[0];
			lfsr = lfsr_next(lfsr);
			// in hold rows nothing comes back while a whole frame still fits
			credit_rtn = rst_n && take && (credit_model < CREDIT_MAX) &&
				!(hold && credit_model >= FRAME_BYTES);
		end
	end

	// ------------------------------------------------------------
	// monitor sampling mid cycle
	// ------------------------------------------------------------

	initial begin
		forever begin
			@(negedge clk_sys);
			if (rst_n) begin
				if (frame_ack && !frame_req) begin
					err_proto++;
					$display("frame_ack was raised without a request at %0t ns", $time);
				end
				if (frame_ack && credit_model < FRAME_BYTES) begin
					err_proto++;
					$display("frame accepted with only %0d credits at %0t ns", credit_model, $time);
				end
				if (frame_req && !frame_ack && credit_model >= FRAME_BYTES) begin
					err_proto++;
					$display("request held back although %0d credits were free at %0t ns",
						credit_model, $time);
				end
				if (tx_vld) begin
					if (exp_q.size() == 0) begin
						err_proto++;
						$display("valid byte %h outside any frame at %0t ns", tx_byte.data, $time);
					end else begin
						check_byte(tx_byte, exp_q.pop_front());
						if (rx_idx == 2) begin
							check_op(pack_pkg::pack_op_e'(tx_byte.data), exp_op);
						end
						rx_idx++;
					end
				end
				credit_model = credit_model + int'(credit_rtn) - int'(tx_vld);
				if (credit_model < 0) begin
					err_proto++;
					$display("sink overflow, more than %0d bytes held at %0t ns", CREDIT_MAX, $time);
				end
			end
		end
	end

	// ------------------------------------------------------------
	// watchdog
	// ------------------------------------------------------------

	initial begin
		repeat (N_ROWS * 200 + 40) @(posedge clk_sys);
		$display("watchdog expired, the frames did not complete in time");
		$display("Test failures found");
		$finish;
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------

	initial begin
		int r;
		rst_n     = 1'b0;
		frame_req = 1'b0;
		frame_in  = '0;
		bm_wr_en  = 1'b0;
		bm_wr     = '0;
		hold      = 1'b0;
		frame_seq = 8'h0;
		rx_idx    = 0;
		exp_op    = pack_pkg::OP_DATA;
		err_byte  = 0;
		err_op    = 0;
		err_proto = 0;
		repeat (16) @(posedge clk_sys);
		#1;
		rst_n = 1'b1;
		repeat (4) @(posedge clk_sys);

		for (r = 0; r < N_ROWS; r++) begin
			hold = ROWS[r].hold;
			write_bitmap(ROWS[r].bitmap);
			load_expected(ROWS[r], frame_seq);
			frame_in.op       = ROWS[r].op;
			frame_in.exp_data = ROWS[r].exp_word;
			frame_req         = 1'b1;
			do begin
				@(negedge clk_sys);
			end while (!frame_ack);
			// request is latched so the inputs are free again
			@(posedge clk_sys);
			#1;
			frame_req = 1'b0;
			frame_in  = '0;
			while (exp_q.size() != 0) begin
				@(posedge clk_sys);
			end
			frame_seq = frame_seq + 8'h1;
		end

		hold = 1'b0;
		repeat (8) @(posedge clk_sys);
		$display("errors: byte %0d, opcode %0d, protocol %0d", err_byte, err_op, err_proto);
		if (err_byte + err_op + err_proto == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+verilog
verilog/pack_pkg.sv
verilog/bm_ram.sv
verilog/pack_head.sv
verilog/pack_tail.sv
verilog/pack_ctrl.sv
verilog/pack_top.sv
tb/tb_pack.sv

//--- Makefile
# Verilator flow for the frame packer

TOP := tb_pack
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing -Wno-fatal -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG)
	cat $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
